//--- lvds_pkg.sv
package lvds_pkg;

    // ---------------------------------------------------------------------
    // link geometry
    // ---------------------------------------------------------------------
    localparam int lane_count      = 8;
    localparam int lanes_per_pixel = 4;     // lanes 0..3 even, 4..7 odd
    localparam int bits_per_lane   = 7;

    typedef logic [bits_per_lane-1:0]                 lane_word_t;
    typedef logic [lanes_per_pixel*bits_per_lane-1:0] pixel_word_t;

    // ---------------------------------------------------------------------
    // field positions in the 28-bit pixel word
    // ---------------------------------------------------------------------
    localparam int f_width = 6;             // wide colour fields
    localparam int g_width = 2;             // narrow colour fields
    localparam int f0_lsb  = 0;
    localparam int f1_lsb  = 6;
    localparam int f2_lsb  = 12;
    localparam int g0_lsb  = 21;
    localparam int g1_lsb  = 23;
    localparam int g2_lsb  = 25;

    localparam int hsync_bit = 18;
    localparam int vsync_bit = 19;
    localparam int de_bit    = 20;          // bit 27 unused

    // raw colour holds one byte per channel as {g, f}, channel 0 in the low byte
    localparam int color_channels = 3;
    localparam int channel_width  = f_width + g_width;

    typedef logic [color_channels*channel_width-1:0] raw_color_t;
    typedef logic [color_channels*channel_width-1:0] rgb_t;

    typedef enum logic {
        lsb_first = 1'b0,                   // {g, f} per channel
        msb_first = 1'b1                    // {f, g} per channel
    } color_mode_t;

endpackage

//--- dps_pkg.sv
package dps_pkg;

    // ---------------------------------------------------------------------
    // sync period counts, in pixel clocks
    // ---------------------------------------------------------------------
    typedef logic [15:0] hsync_period_t;
    typedef logic [23:0] vsync_period_t;

    // ---------------------------------------------------------------------
    // phase step controller
    // ---------------------------------------------------------------------
    typedef enum logic [1:0] {
        idle      = 2'd0,
        step      = 2'd1,               // step request held
        ack       = 2'd2,               // waiting for done to return
        reset_pll = 2'd3
    } phase_state_t;

endpackage

//--- pixel_if.sv
`timescale 1ns/1ps

interface pixel_if
    import lvds_pkg::*;
();

    logic       hsync;                  // link level, active low
    logic       vsync;                  // link level, active low
    logic       de;
    raw_color_t raw_color;

    modport source (
        output hsync, vsync, de, raw_color
    );

    modport sink (
        input hsync, vsync, de, raw_color
    );

endinterface

//--- lane_deserializer.sv
`timescale 1ns/1ps

module lane_deserializer
    import lvds_pkg::*;
(
    input  logic                  clk,
    input  logic                  serial_clk_i,
    input  logic [lane_count-1:0] serial_data_i,
    output lane_word_t            lane_words_o [lane_count]
);

    genvar lane;

    generate
        for (lane = 0; lane < lane_count; lane++)
        begin : g_lane
            logic       data_meta;          // input register
            logic       data_q;
            lane_word_t shift_q;

            // serial domain, one bit per serial edge
            always_ff @(posedge serial_clk_i)
            begin
                data_meta <= serial_data_i[lane];
                data_q    <= data_meta;
                shift_q   <= {shift_q[bits_per_lane-2:0], data_q};  // oldest bit to msb
            end

            // clk edges coincide with a serial edge, so shift_q is stable here
            always_ff @(posedge clk)
            begin
                lane_words_o[lane] <= shift_q;
            end
        end
    endgenerate

endmodule

//--- pixel_capture.sv
`timescale 1ns/1ps

module pixel_capture
    import lvds_pkg::*;
(
    input  logic       clk,
    input  logic       reset_n,
    input  lane_word_t lane_words_i [lane_count],
    pixel_if.source    even_o,
    pixel_if.source    odd_o
);

    logic        reset_n_q;                 // released on the pixel clock
    pixel_word_t even_word;
    pixel_word_t odd_word;

    function automatic raw_color_t unpack_color(input pixel_word_t word);
        return {word[g2_lsb +: g_width], word[f2_lsb +: f_width],
                word[g1_lsb +: g_width], word[f1_lsb +: f_width],
                word[g0_lsb +: g_width], word[f0_lsb +: f_width]};
    endfunction

    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
            reset_n_q <= 1'b0;
        else
            reset_n_q <= 1'b1;
    end

    always_ff @(posedge clk or negedge reset_n_q)
    begin
        if (!reset_n_q)
        begin
            even_word <= '0;
            odd_word  <= '0;
        end
        else
        begin
            for (int p = 0; p < lanes_per_pixel; p++)
            begin
                even_word[p*bits_per_lane +: bits_per_lane] <= lane_words_i[p];
                odd_word[p*bits_per_lane +: bits_per_lane]  <= lane_words_i[p + lanes_per_pixel];
            end
        end
    end

    assign even_o.hsync     = even_word[hsync_bit];
    assign even_o.vsync     = even_word[vsync_bit];
    assign even_o.de        = even_word[de_bit];
    assign even_o.raw_color = unpack_color(even_word);

    assign odd_o.hsync      = odd_word[hsync_bit];
    assign odd_o.vsync      = odd_word[vsync_bit];
    assign odd_o.de         = odd_word[de_bit];
    assign odd_o.raw_color  = unpack_color(odd_word);

endmodule

//--- pixel_formatter.sv
`timescale 1ns/1ps

module pixel_formatter
    import lvds_pkg::*;
(
    input  logic        clk,
    input  logic        reset_n,
    input  color_mode_t color_mode_i,
    pixel_if.sink       pix,
    output logic        hsync_n_o,
    output logic        vsync_n_o,
    output logic        de_o,
    output rgb_t        data_o
);

    color_mode_t color_mode_q;
    rgb_t        rgb;

    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
            color_mode_q <= lsb_first;
        else
            color_mode_q <= color_mode_i;
    end

    // channel 0 is red and goes to the top byte
    always_comb
    begin
        logic [channel_width-1:0] chan;
        for (int ch = 0; ch < color_channels; ch++)
        begin
            chan = pix.raw_color[ch*channel_width +: channel_width];
            if (color_mode_q == msb_first)
                chan = {chan[f_width-1:0], chan[channel_width-1 -: g_width]};
            rgb[(color_channels-1-ch)*channel_width +: channel_width] = chan;
        end
    end

    // colour registered with the syncs so both stay aligned
    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
        begin
            hsync_n_o <= 1'b0;
            vsync_n_o <= 1'b0;
            de_o      <= 1'b0;
            data_o    <= '0;
        end
        else
        begin
            hsync_n_o <= pix.hsync;
            vsync_n_o <= pix.vsync;
            de_o      <= pix.de;
            data_o    <= rgb;
        end
    end

endmodule

//--- sync_period_monitor.sv
`timescale 1ns/1ps

module sync_period_monitor #(
    parameter int                      period_width = 16,
    parameter logic [period_width-1:0] min_period   = '0,
    parameter logic [period_width-1:0] max_period   = '1
) (
    input  logic clk,
    input  logic reset_n,
    input  logic sync_i,
    output logic in_range_o
);

    logic                    sync_meta;
    logic                    sync_q;
    logic                    sync_d;        // previous synchronized level
    logic                    sync_rise;
    logic [period_width-1:0] period_cnt;

    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
        begin
            sync_meta <= 1'b0;
            sync_q    <= 1'b0;
            sync_d    <= 1'b0;
        end
        else
        begin
            sync_meta <= sync_i;
            sync_q    <= sync_meta;
            sync_d    <= sync_q;
        end
    end

    assign sync_rise = sync_q && !sync_d;

    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
        begin
            period_cnt <= '0;
            in_range_o <= 1'b0;
        end
        else if (period_cnt > max_period)   // sync lost
        begin
            period_cnt <= '0;
            in_range_o <= 1'b0;
        end
        else if (sync_rise)
        begin
            in_range_o <= (period_cnt >= min_period) && (period_cnt < max_period);
            period_cnt <= '0;
        end
        else
        begin
            period_cnt <= period_cnt + 1'b1;
        end
    end

endmodule

//--- phase_step_fsm.sv
`timescale 1ns/1ps

module phase_step_fsm
    import dps_pkg::*;
#(
    parameter int        lock_timeout = 5000000,
    parameter int signed post_steps   = 0
) (
    input  logic clk,
    input  logic reset_n,
    input  logic hsync_ok_i,
    input  logic vsync_ok_i,
    input  logic dps_done_i,
    output logic dps_reset_o,
    output logic dps_step_o,
    output logic dps_dir_o,
    output logic locked_o
);

    localparam int post_abs    = (post_steps < 0) ? -post_steps : post_steps;
    localparam int timer_width = $clog2(lock_timeout + 1);
    localparam int post_width  = $clog2(post_abs + 1) + 1;

    localparam logic [timer_width-1:0] timer_last = timer_width'(lock_timeout - 1);

    logic                         done_neg;     // falling edge capture
    logic                         done_meta;
    logic                         done_sync;
    logic                         syncs_ok;
    logic                         timer_expired;
    logic        [timer_width-1:0] timer;
    logic signed [post_width-1:0]  post_cnt;
    phase_state_t                 state;

    // ---------------------------------------------------------------------
    // done synchronizer
    // ---------------------------------------------------------------------
    always_ff @(negedge clk or negedge reset_n)
    begin
        if (!reset_n)
            done_neg <= 1'b1;
        else
            done_neg <= dps_done_i;
    end

    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
        begin
            done_meta <= 1'b1;
            done_sync <= 1'b1;
        end
        else
        begin
            done_meta <= done_neg;
            done_sync <= done_meta;
        end
    end

    assign syncs_ok      = hsync_ok_i && vsync_ok_i;
    assign timer_expired = (timer >= timer_last);

    // ---------------------------------------------------------------------
    // step state machine
    // ---------------------------------------------------------------------
    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
        begin
            state       <= reset_pll;
            timer       <= '0;
            post_cnt    <= '0;
            dps_reset_o <= 1'b0;
            dps_step_o  <= 1'b0;
            dps_dir_o   <= 1'b0;
            locked_o    <= 1'b0;
        end
        else
        begin
            dps_reset_o <= 1'b0;
            locked_o    <= 1'b0;
            case (state)
                idle:
                begin
                    dps_step_o <= 1'b0;
                    if (syncs_ok)
                    begin
                        if (post_cnt > 0)
                        begin
                            dps_dir_o <= 1'b1;          // step up
                            post_cnt  <= post_cnt - post_width'(1);
                            state     <= step;
                        end
                        else if (post_cnt < 0)
                        begin
                            dps_dir_o <= 1'b0;
                            post_cnt  <= post_cnt + post_width'(1);
                            state     <= step;
                        end
                        else
                            locked_o <= 1'b1;
                    end
                    else if (!timer_expired)
                        timer <= timer + 1'b1;
                    else
                    begin
                        dps_dir_o <= 1'b1;
                        post_cnt  <= post_width'(post_steps);
                        timer     <= '0;
                        state     <= step;
                    end
                end

                step:
                begin
                    dps_step_o <= 1'b1;
                    if (!done_sync)                     // PLL took the step
                    begin
                        dps_step_o <= 1'b0;
                        timer      <= '0;
                        state      <= ack;
                    end
                    else if (!timer_expired)
                        timer <= timer + 1'b1;
                    else
                    begin
                        timer <= '0;
                        state <= reset_pll;
                    end
                end

                ack:
                begin
                    dps_step_o <= 1'b0;
                    if (done_sync)
                    begin
                        timer <= '0;
                        state <= idle;
                    end
                    else if (!timer_expired)
                        timer <= timer + 1'b1;
                    else
                    begin
                        timer <= '0;
                        state <= reset_pll;
                    end
                end

                default:                                // reset_pll
                begin
                    dps_reset_o <= 1'b1;
                    dps_step_o  <= 1'b0;
                    dps_dir_o   <= 1'b0;
                    timer       <= '0;
                    post_cnt    <= '0;
                    state       <= idle;
                end
            endcase
        end
    end

endmodule

//--- lvds_receiver_2px.sv
`timescale 1ns/1ps

module lvds_receiver_2px
    import lvds_pkg::*;
    import dps_pkg::*;
#(
    parameter hsync_period_t hsync_min_period = 16'd512,
    parameter hsync_period_t hsync_max_period = 16'd65534,
    parameter vsync_period_t vsync_min_period = 24'd65536,
    parameter vsync_period_t vsync_max_period = 24'd16777214,
    parameter int            lock_timeout     = 5000000,
    parameter int signed     post_steps       = 0
) (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  serial_clk_i,
    input  logic [lane_count-1:0] serial_data_i,
    input  color_mode_t           color_mode_i,
    input  logic                  dps_done_i,
    output logic                  even_hsync_n_o,
    output logic                  even_vsync_n_o,
    output logic                  even_de_o,
    output rgb_t                  even_data_o,
    output logic                  odd_hsync_n_o,
    output logic                  odd_vsync_n_o,
    output logic                  odd_de_o,
    output rgb_t                  odd_data_o,
    output logic                  dps_reset_o,
    output logic                  dps_step_o,
    output logic                  dps_dir_o,
    output logic                  locked_o
);

    lane_word_t lane_words [lane_count];
    logic       hsync_ok;
    logic       vsync_ok;

    pixel_if even_pix ();
    pixel_if odd_pix ();

    // ---------------------------------------------------------------------
    // data path
    // ---------------------------------------------------------------------
    lane_deserializer u_deser (
        .clk           (clk),
        .serial_clk_i  (serial_clk_i),
        .serial_data_i (serial_data_i),
        .lane_words_o  (lane_words)
    );

    pixel_capture u_capture (
        .clk          (clk),
        .reset_n      (reset_n),
        .lane_words_i (lane_words),
        .even_o       (even_pix),
        .odd_o        (odd_pix)
    );

    pixel_formatter u_even_fmt (
        .clk          (clk),
        .reset_n      (reset_n),
        .color_mode_i (color_mode_i),
        .pix          (even_pix),
        .hsync_n_o    (even_hsync_n_o),
        .vsync_n_o    (even_vsync_n_o),
        .de_o         (even_de_o),
        .data_o       (even_data_o)
    );

    pixel_formatter u_odd_fmt (
        .clk          (clk),
        .reset_n      (reset_n),
        .color_mode_i (color_mode_i),
        .pix          (odd_pix),
        .hsync_n_o    (odd_hsync_n_o),
        .vsync_n_o    (odd_vsync_n_o),
        .de_o         (odd_de_o),
        .data_o       (odd_data_o)
    );

    // ---------------------------------------------------------------------
    // link health and sampling phase, judged on the even pixel
    // ---------------------------------------------------------------------
    sync_period_monitor #(
        .period_width ($bits(hsync_period_t)),
        .min_period   (hsync_min_period),
        .max_period   (hsync_max_period)
    ) u_hsync_mon (
        .clk        (clk),
        .reset_n    (reset_n),
        .sync_i     (even_pix.hsync),
        .in_range_o (hsync_ok)
    );

    sync_period_monitor #(
        .period_width ($bits(vsync_period_t)),
        .min_period   (vsync_min_period),
        .max_period   (vsync_max_period)
    ) u_vsync_mon (
        .clk        (clk),
        .reset_n    (reset_n),
        .sync_i     (even_pix.vsync),
        .in_range_o (vsync_ok)
    );

    phase_step_fsm #(
        .lock_timeout (lock_timeout),
        .post_steps   (post_steps)
    ) u_phase_fsm (
        .clk         (clk),
        .reset_n     (reset_n),
        .hsync_ok_i  (hsync_ok),
        .vsync_ok_i  (vsync_ok),
        .dps_done_i  (dps_done_i),
        .dps_reset_o (dps_reset_o),
        .dps_step_o  (dps_step_o),
        .dps_dir_o   (dps_dir_o),
        .locked_o    (locked_o)
    );

endmodule

//--- tb_lvds_receiver.sv
`timescale 1ns/1ps

module tb_lvds_receiver
    import lvds_pkg::*;
();

    localparam int reset_cycles   = 10;
    localparam int t1_cycles      = 6;
    localparam int t2_cycles      = 4 * 8 + 4;
    localparam int step_wait      = 300;      // lock timeout is 200
    localparam int lock_wait      = 600;
    localparam int hold_cycles    = 300;
    localparam int loss_wait      = 40;
    localparam int nack_wait      = 600;
    localparam int watchdog_cycles = 2 * reset_cycles + t1_cycles + 2 * t2_cycles + step_wait
                                   + lock_wait + hold_cycles + 16 + loss_wait + nack_wait + 500;

    logic        clk;
    logic        reset_n;
    logic        serial_clk;
    logic [7:0]  serial_data;
    color_mode_t color_mode;
    logic        dps_done;
    logic        even_hsync_n, even_vsync_n, even_de;
    logic        odd_hsync_n, odd_vsync_n, odd_de;
    rgb_t        even_data, odd_data;
    logic        dps_reset, dps_step, dps_dir, locked;

    logic [27:0] tx_even;                      // word for the next lane slot
    logic [27:0] tx_odd;
    logic        pll_ignore;
    logic        hs_hold;
    int          pix_cnt;
    integer      seed;
    int          errors;
    int          prop_errors;
    int          tests_run;
    int          tests_passed;

    lvds_receiver_2px #(
        .hsync_min_period (16'd8),
        .hsync_max_period (16'd32),
        .vsync_min_period (24'd64),
        .vsync_max_period (24'd256),
        .lock_timeout     (200),
        .post_steps       (2)
    ) dut0 (
        .clk (clk), .reset_n (reset_n), .serial_clk_i (serial_clk),
        .serial_data_i (serial_data), .color_mode_i (color_mode), .dps_done_i (dps_done),
        .even_hsync_n_o (even_hsync_n), .even_vsync_n_o (even_vsync_n),
        .even_de_o (even_de), .even_data_o (even_data),
        .odd_hsync_n_o (odd_hsync_n), .odd_vsync_n_o (odd_vsync_n),
        .odd_de_o (odd_de), .odd_data_o (odd_data),
        .dps_reset_o (dps_reset), .dps_step_o (dps_step), .dps_dir_o (dps_dir),
        .locked_o (locked)
    );

    // ----------------------------------------------------------------------
    // clocks and serial stream, seven serial periods per pixel clock
    // ----------------------------------------------------------------------
    initial
    begin
        logic [27:0] sh_even;
        logic [27:0] sh_odd;
        int          j;
        int          b;
        real         half;
        clk         = 1'b0;
        serial_clk  = 1'b0;
        serial_data = '0;
        sh_even     = '0;
        sh_odd      = '0;
        forever
        begin
            for (int h = 0; h < 14; h++)
            begin
                half = ((h % 7) < 2) ? 0.715 : 0.714;    // 14 halves make 10 ns
                if (h % 2 == 0)
                begin
                    serial_clk = 1'b1;
                    if (h == 0)
                        clk = 1'b1;
                end
                else
                begin
                    serial_clk = 1'b0;
                    if (h == 7)
                        clk = 1'b0;
                    j = ((h + 1) / 2) % 7;                // slot of the next rising edge
                    if (j == 5)
                    begin
                        sh_even = tx_even;
                        sh_odd  = tx_odd;
                    end
                    b = (j >= 5) ? 11 - j : 4 - j;        // earliest bit is bit 6
                    for (int l = 0; l < 4; l++)
                    begin
                        serial_data[l]     = sh_even[l*7 + b];
                        serial_data[l + 4] = sh_odd[l*7 + b];
                    end
                end
                #(half);
            end
        end
    end

    // PLL phase port model
    initial
    begin
        dps_done = 1'b1;
        forever
        begin
            @(posedge dps_step);
            if (!pll_ignore)
            begin
                @(negedge clk);
                dps_done = 1'b0;
                repeat (3) @(negedge clk);
                dps_done = 1'b1;
            end
        end
    end

    initial
    begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("watchdog expired before the tests finished");
        $display("Test failed");
        $finish;
    end

    step_reset_excl: assert property (@(posedge clk) disable iff (!reset_n)
                                      !(dps_step && dps_reset))
    else
    begin
        $display("dps_step_o and dps_reset_o high together");
        prop_errors++;
    end

    lock_no_step: assert property (@(posedge clk) disable iff (!reset_n) locked |-> !dps_step)
    else
    begin
        $display("locked_o high during a phase step");
        prop_errors++;
    end

    // ----------------------------------------------------------------------
    // helpers
    // ----------------------------------------------------------------------
    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        assert (actual === expected)
        else
        begin
            $display("mismatch %s expected %h actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string msg);
        assert (cond === 1'b1)
        else
        begin
            $display("%s", msg);
            errors++;
        end
    endtask

    task automatic end_test(input string name, input int start_errors);
        int n;
        n = errors + prop_errors - start_errors;
        tests_run++;
        if (n == 0)
        begin
            tests_passed++;
            $display("test %s passed", name);
        end
        else
            $display("test %s failed with %0d errors", name, n);
    endtask

    task automatic apply_reset();
        @(negedge clk);
        reset_n = 1'b0;
        repeat (reset_cycles) @(negedge clk);
        reset_n = 1'b1;
    endtask

    // one pixel of a frame with hsync period 16 and vsync period 128
    task automatic drive_sync_pixel();
        pix_cnt++;
        tx_even     = '0;
        tx_even[18] = !hs_hold && (pix_cnt % 16 == 0);
        tx_even[19] = (pix_cnt % 128 == 0);
        tx_even[20] = 1'b1;
        tx_odd      = tx_even;
    endtask

    function automatic logic [23:0] map_color(input logic [27:0] w, input color_mode_t mode);
        if (mode == msb_first)
            return {w[5:0], w[22:21], w[11:6], w[24:23], w[17:12], w[26:25]};
        return {w[22:21], w[5:0], w[24:23], w[11:6], w[26:25], w[17:12]};
    endfunction

    task automatic check_colors(input string name, input color_mode_t mode);
        for (int i = 0; i < 4; i++)
        begin
            @(negedge clk);
            tx_even = 28'($random(seed));
            tx_odd  = 28'($random(seed));
            repeat (4) @(negedge clk);              // lane word plus two edges
            check_value({name, "_even_data"}, map_color(tx_even, mode), even_data);
            check_value({name, "_odd_data"}, map_color(tx_odd, mode), odd_data);
            check_value({name, "_even_ctrl"}, {tx_even[18], tx_even[19], tx_even[20]},
                        {even_hsync_n, even_vsync_n, even_de});
            check_value({name, "_odd_ctrl"}, {tx_odd[18], tx_odd[19], tx_odd[20]},
                        {odd_hsync_n, odd_vsync_n, odd_de});
            repeat (3) @(negedge clk);
        end
    endtask

    // ----------------------------------------------------------------------
    // tests
    // ----------------------------------------------------------------------
    initial
    begin
        int start;
        int pulses;
        int waited;
        int rises;
        int lost;
        int held;
        logic step_prev;
        seed = 96;
        errors = 0;
        prop_errors = 0;
        tests_run = 0;
        tests_passed = 0;
        reset_n = 1'b0;
        color_mode = lsb_first;
        tx_even = '1;                               // nonzero words through reset
        tx_odd = '1;
        pll_ignore = 1'b0;
        hs_hold = 1'b0;
        pix_cnt = 0;

        start = 0;
        apply_reset();
        pulses = 0;
        for (int i = 0; i < t1_cycles; i++)
        begin
            // capture leaves reset one edge late, outputs stay clear for two cycles
            if (i < 3)
                check_value("reset_pixels", 0, {even_hsync_n, even_vsync_n, even_de,
                                                even_data, odd_hsync_n, odd_vsync_n,
                                                odd_de, odd_data});
            @(negedge clk);
            pulses += dps_reset;
            check_value("reset_step_lock", 0, {dps_step, locked});
        end
        check_value("reset_pulse_count", 1, pulses);
        end_test("reset", start);

        start = errors + prop_errors;
        check_colors("lsb_first", lsb_first);
        end_test("lsb_first", start);

        start = errors + prop_errors;
        @(negedge clk);
        color_mode = msb_first;
        repeat (3) @(negedge clk);
        check_colors("msb_first", msb_first);
        end_test("msb_first", start);

        // stepping with syncs absent, then post-steps once they are valid
        start = errors + prop_errors;
        tx_even = '0;
        tx_odd = '0;
        apply_reset();
        waited = 0;
        while (!dps_step && waited < step_wait)
        begin
            @(negedge clk);
            waited++;
        end
        check_true(dps_step, "no step request after the lock timeout");
        check_true(waited >= 150, "step request came before the lock timeout");
        check_value("stepping_first_dir", 1, dps_dir);
        step_prev = 1'b1;
        rises = 0;
        waited = 0;
        while (!locked && waited < lock_wait)
        begin
            @(negedge clk);
            drive_sync_pixel();
            waited++;
            if (dps_step && !step_prev)
            begin
                rises++;
                check_value("stepping_post_dir", 1, dps_dir);
            end
            step_prev = dps_step;
        end
        check_true(locked, "locked_o did not rise after valid syncs were supplied");
        check_value("stepping_post_count", 2, rises);
        lost = 0;
        for (int i = 0; i < hold_cycles; i++)
        begin
            @(negedge clk);
            drive_sync_pixel();
            lost += !locked;
        end
        check_value("stepping_lock_held", 0, lost);
        end_test("stepping", start);

        start = errors + prop_errors;
        while (pix_cnt % 16 != 8)
        begin
            @(negedge clk);
            drive_sync_pixel();
        end
        hs_hold = 1'b1;
        waited = 0;
        while (locked && waited < loss_wait)
        begin
            @(negedge clk);
            drive_sync_pixel();
            waited++;
        end
        check_true(!locked, "locked_o still high 40 cycles after hsync stopped");
        end_test("lock_loss", start);

        // PLL that never acknowledges
        start = errors + prop_errors;
        pll_ignore = 1'b1;
        waited = 0;
        while (!dps_step && waited < step_wait)
        begin
            @(negedge clk);
            drive_sync_pixel();
            waited++;
        end
        check_true(dps_step, "no step request while syncs were out of range");
        held = 0;
        while (!dps_reset && held < nack_wait)
        begin
            @(negedge clk);
            drive_sync_pixel();
            if (!dps_reset)
            begin
                check_true(dps_step, "dps_step_o dropped without an acknowledge");
                held++;
            end
        end
        check_true(dps_reset, "no PLL reset after an unacknowledged step");
        check_true(held >= 150, "PLL reset came before the step timeout");
        @(negedge clk);
        check_value("no_ack_reset_len", 0, dps_reset);
        end_test("no_ack", start);

        $display("tests run %0d, passed %0d, failed %0d, errors %0d", tests_run, tests_passed,
                 tests_run - tests_passed, errors + prop_errors);
        if (errors + prop_errors == 0 && tests_passed == tests_run)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

//--- filelist.f
lvds_pkg.sv
dps_pkg.sv
pixel_if.sv
lane_deserializer.sv
pixel_capture.sv
pixel_formatter.sv
sync_period_monitor.sv
phase_step_fsm.sv
lvds_receiver_2px.sv
tb_lvds_receiver.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_lvds_receiver
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test completed successfully"

clean:
	rm -rf $(OBJ_DIR)
